// ==== Bender.yml ====
package:
  name: dual_core_bus

dependencies: {}

sources:
  - files:
      - design/bus_pkg.sv
      - design/mem_map_pkg.sv
      - design/bus_arbiter.sv
      - design/req_stage.sv
      - design/shared_ram.sv
      - design/mmio_regs.sv
      - design/dual_core_bus.sv
  - target: test
    files:
      - tests/tb_dual_core_bus.sv

// ==== design/bus_arbiter.sv ====
/* Round-robin bus arbiter for two cores.
   Switches the grant at the decode point and steers requests and responses. */

`timescale 1ns/100ps
`default_nettype none

module bus_arbiter
    import bus_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RST_X,

    input  logic [CPUSTATE_W-1:0] cpustate0,
    input  logic [XLEN-1:0]       paddr0,
    input  logic                  we0,
    input  logic                  le0,
    input  logic [XLEN-1:0]       wdata0,
    output logic [XLEN-1:0]       rdata0,
    output logic                  busy0,

    input  logic [CPUSTATE_W-1:0] cpustate1,
    input  logic [XLEN-1:0]       paddr1,
    input  logic                  we1,
    input  logic                  le1,
    input  logic [XLEN-1:0]       wdata1,
    output logic [XLEN-1:0]       rdata1,
    output logic                  busy1,

    output logic [XLEN-1:0]       req_addr,
    output logic                  req_we,
    output logic                  req_le,
    output logic [XLEN-1:0]       req_wdata,
    input  logic                  stage_busy,
    input  logic [XLEN-1:0]       stage_rdata
);

    logic [CORE_ID_W-1:0]   grant;
    logic [ARB_STATE_W-1:0] state;
    logic [HOLD_CNT_W-1:0]  hold_cnt;

    logic [CPUSTATE_W-1:0]  cur_cpustate;
    logic                   cur_we;
    logic                   cur_le;
    logic                   open_win;
    logic                   gnt_busy;

    // ************************************************************
    // Grant FSM
    // ************************************************************
    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            grant    <= '0;
            state    <= ARB_RUN;
            hold_cnt <= '0;
        end else begin
            case (state)
                ARB_RUN: begin
                    // Only hand over with nothing in flight or starting.
                    if (cur_cpustate == S_ID && !stage_busy && !cur_we && !cur_le) begin
                        state <= ARB_SWITCH;
                    end
                end
                ARB_SWITCH: begin
                    if (grant == CORE_ID_W'(NCORES - 1)) begin
                        grant <= '0;
                    end else begin
                        grant <= grant + 1'b1;
                    end
                    state <= ARB_SETTLE;
                end
                ARB_SETTLE: begin
                    hold_cnt <= '0;
                    state    <= ARB_HOLD;
                end
                default: begin
                    if (hold_cnt == HOLD_CNT_W'(HOLD_CYCLES - 1)) begin
                        state <= ARB_RUN;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // ************************************************************
    // Request mux and response steering
    // ************************************************************
    assign open_win = (state == ARB_RUN) || (state == ARB_HOLD);
    assign gnt_busy = open_win ? stage_busy : 1'b1;

    always_comb begin
        if (grant == '0) begin
            cur_cpustate = cpustate0;
            cur_we       = we0;
            cur_le       = le0;
            req_addr     = paddr0;
            req_wdata    = wdata0;
        end else begin
            cur_cpustate = cpustate1;
            cur_we       = we1;
            cur_le       = le1;
            req_addr     = paddr1;
            req_wdata    = wdata1;
        end
    end

    assign req_we = open_win && cur_we;
    assign req_le = open_win && cur_le;

    // The idle core sees a stalled bus with zero data.
    always_comb begin
        if (grant == '0) begin
            rdata0 = stage_rdata;
            busy0  = gnt_busy;
            rdata1 = '0;
            busy1  = 1'b1;
        end else begin
            rdata1 = stage_rdata;
            busy1  = gnt_busy;
            rdata0 = '0;
            busy0  = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/bus_pkg.sv ====
/* Core-side bus constants.
   Widths, core count, cpustate codes and arbiter state codes. */

`default_nettype none

package bus_pkg;

    // ************************************************************
    // Core side of the bus
    // ************************************************************
    localparam int NCORES     = 2;
    localparam int CORE_ID_W  = 1;
    localparam int XLEN       = 32;
    localparam int CPUSTATE_W = 4;

    // Decode point, safe to hand the bus over.
    localparam logic [CPUSTATE_W-1:0] S_ID = 4'd0;

    // ************************************************************
    // Arbiter
    // ************************************************************
    localparam int HOLD_CYCLES = 2;
    localparam int HOLD_CNT_W  = 2;

    localparam int ARB_STATE_W = 2;
    localparam logic [ARB_STATE_W-1:0] ARB_RUN    = 2'd0;
    localparam logic [ARB_STATE_W-1:0] ARB_SWITCH = 2'd1;
    localparam logic [ARB_STATE_W-1:0] ARB_SETTLE = 2'd2;
    localparam logic [ARB_STATE_W-1:0] ARB_HOLD   = 2'd3;

endpackage

`default_nettype wire

// ==== design/dual_core_bus.sv ====
/* Dual-core shared bus top level.
   Arbiter, request stage, shared RAM and timer block. */

`timescale 1ns/100ps
`default_nettype none

module dual_core_bus
    import bus_pkg::*;
    import mem_map_pkg::*;
(
    input  logic                  CLK,
    input  logic                  RST_X,

    input  logic [CPUSTATE_W-1:0] cpustate0,
    input  logic [XLEN-1:0]       paddr0,
    input  logic                  we0,
    input  logic                  le0,
    input  logic [XLEN-1:0]       wdata0,
    output logic [XLEN-1:0]       rdata0,
    output logic                  busy0,

    input  logic [CPUSTATE_W-1:0] cpustate1,
    input  logic [XLEN-1:0]       paddr1,
    input  logic                  we1,
    input  logic                  le1,
    input  logic [XLEN-1:0]       wdata1,
    output logic [XLEN-1:0]       rdata1,
    output logic                  busy1,

    output logic [XLEN-1:0]       mip
);

    logic [XLEN-1:0]      req_addr;
    logic                 req_we;
    logic                 req_le;
    logic [XLEN-1:0]      req_wdata;
    logic                 stage_busy;
    logic [XLEN-1:0]      stage_rdata;

    logic [RAM_IDX_W-1:0] ram_idx;
    logic                 ram_we;
    logic                 ram_re;
    logic [XLEN-1:0]      ram_wdata;
    logic [XLEN-1:0]      ram_rdata;

    logic [TMR_SEL_W-1:0] tmr_sel;
    logic                 tmr_we;
    logic                 tmr_re;
    logic [XLEN-1:0]      tmr_wdata;
    logic [XLEN-1:0]      tmr_rdata;

    bus_arbiter u_bus_arbiter (
        .CLK         (CLK),
        .RST_X       (RST_X),
        .cpustate0   (cpustate0),
        .paddr0      (paddr0),
        .we0         (we0),
        .le0         (le0),
        .wdata0      (wdata0),
        .rdata0      (rdata0),
        .busy0       (busy0),
        .cpustate1   (cpustate1),
        .paddr1      (paddr1),
        .we1         (we1),
        .le1         (le1),
        .wdata1      (wdata1),
        .rdata1      (rdata1),
        .busy1       (busy1),
        .req_addr    (req_addr),
        .req_we      (req_we),
        .req_le      (req_le),
        .req_wdata   (req_wdata),
        .stage_busy  (stage_busy),
        .stage_rdata (stage_rdata)
    );

    req_stage u_req_stage (
        .CLK         (CLK),
        .RST_X       (RST_X),
        .req_addr    (req_addr),
        .req_we      (req_we),
        .req_le      (req_le),
        .req_wdata   (req_wdata),
        .stage_busy  (stage_busy),
        .stage_rdata (stage_rdata),
        .ram_idx     (ram_idx),
        .ram_we      (ram_we),
        .ram_re      (ram_re),
        .ram_wdata   (ram_wdata),
        .ram_rdata   (ram_rdata),
        .tmr_sel     (tmr_sel),
        .tmr_we      (tmr_we),
        .tmr_re      (tmr_re),
        .tmr_wdata   (tmr_wdata),
        .tmr_rdata   (tmr_rdata)
    );

    shared_ram u_shared_ram (
        .CLK       (CLK),
        .ram_idx   (ram_idx),
        .ram_we    (ram_we),
        .ram_re    (ram_re),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    mmio_regs u_mmio_regs (
        .CLK       (CLK),
        .RST_X     (RST_X),
        .tmr_sel   (tmr_sel),
        .tmr_we    (tmr_we),
        .tmr_re    (tmr_re),
        .tmr_wdata (tmr_wdata),
        .tmr_rdata (tmr_rdata),
        .mip       (mip)
    );

endmodule

`default_nettype wire

// ==== design/mem_map_pkg.sv ====
/* Address map of the shared bus.
   Region codes, RAM size, timer register selects and the address union. */

`default_nettype none

package mem_map_pkg;

    localparam int REGION_W = 4;
    localparam logic [REGION_W-1:0] RAM_REGION  = 4'h8;
    localparam logic [REGION_W-1:0] MMIO_REGION = 4'h2;

    localparam int RAM_WORDS  = 1024;
    localparam int RAM_IDX_W  = 10;
    // Cycles from the RAM read strobe to valid data.
    localparam int RAM_RD_LAT = 2;

    localparam int TMR_SEL_W = 3;
    localparam logic [TMR_SEL_W-1:0] TMR_MTIME_LO    = 3'd0;
    localparam logic [TMR_SEL_W-1:0] TMR_MTIME_HI    = 3'd1;
    localparam logic [TMR_SEL_W-1:0] TMR_MTIMECMP_LO = 3'd2;
    localparam logic [TMR_SEL_W-1:0] TMR_MTIMECMP_HI = 3'd3;
    localparam logic [TMR_SEL_W-1:0] TMR_MSIP        = 3'd4;

    // One 32-bit bus address, seen as a RAM word or a timer register.
    typedef union packed {
        struct packed {
            logic [REGION_W-1:0]  region;
            logic [15:0]          unused;
            logic [RAM_IDX_W-1:0] word;
            logic [1:0]           byte_off;
        } ram;
        struct packed {
            logic [REGION_W-1:0]  region;
            logic [22:0]          unused;
            logic [TMR_SEL_W-1:0] sel;
            logic [1:0]           byte_off;
        } mmio;
    } bus_addr_u;

endpackage

`default_nettype wire

// ==== design/mmio_regs.sv ====
/* Machine timer and software interrupt registers.
   Runs mtime, compares against mtimecmp and drives MTIP and MSIP. */

`timescale 1ns/100ps
`default_nettype none

module mmio_regs
    import bus_pkg::*;
    import mem_map_pkg::*;
(
    input  logic                 CLK,
    input  logic                 RST_X,
    input  logic [TMR_SEL_W-1:0] tmr_sel,
    input  logic                 tmr_we,
    input  logic                 tmr_re,
    input  logic [XLEN-1:0]      tmr_wdata,
    output logic [XLEN-1:0]      tmr_rdata,
    output logic [XLEN-1:0]      mip
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        msip;
    logic        mtip;

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            mtime    <= '0;
            mtimecmp <= '1;
            msip     <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (tmr_we) begin
                case (tmr_sel)
                    TMR_MTIMECMP_LO: mtimecmp[31:0]  <= tmr_wdata;
                    TMR_MTIMECMP_HI: mtimecmp[63:32] <= tmr_wdata;
                    TMR_MSIP:        msip            <= tmr_wdata[0];
                    default: ;
                endcase
            end
        end
    end

    // One-cycle registered read.
    always_ff @(posedge CLK) begin
        if (tmr_re) begin
            case (tmr_sel)
                TMR_MTIME_LO:    tmr_rdata <= mtime[31:0];
                TMR_MTIME_HI:    tmr_rdata <= mtime[63:32];
                TMR_MTIMECMP_LO: tmr_rdata <= mtimecmp[31:0];
                TMR_MTIMECMP_HI: tmr_rdata <= mtimecmp[63:32];
                TMR_MSIP:        tmr_rdata <= {{(XLEN-1){1'b0}}, msip};
                default:         tmr_rdata <= '0;
            endcase
        end
    end

    assign mtip = (mtime >= mtimecmp);

    // MTIP is bit 7, MSIP is bit 3.
    always_comb begin
        mip    = '0;
        mip[7] = mtip;
        mip[3] = msip;
    end

endmodule

`default_nettype wire

// ==== design/req_stage.sv ====
/* Request register stage.
   Decodes the granted address, strobes one target and times completion. */

`timescale 1ns/100ps
`default_nettype none

module req_stage
    import bus_pkg::*;
    import mem_map_pkg::*;
(
    input  logic                 CLK,
    input  logic                 RST_X,
    input  logic [XLEN-1:0]      req_addr,
    input  logic                 req_we,
    input  logic                 req_le,
    input  logic [XLEN-1:0]      req_wdata,
    output logic                 stage_busy,
    output logic [XLEN-1:0]      stage_rdata,

    output logic [RAM_IDX_W-1:0] ram_idx,
    output logic                 ram_we,
    output logic                 ram_re,
    output logic [XLEN-1:0]      ram_wdata,
    input  logic [XLEN-1:0]      ram_rdata,

    output logic [TMR_SEL_W-1:0] tmr_sel,
    output logic                 tmr_we,
    output logic                 tmr_re,
    output logic [XLEN-1:0]      tmr_wdata,
    input  logic [XLEN-1:0]      tmr_rdata
);

    bus_addr_u       addr;
    logic            is_ram;
    logic            is_tmr;
    logic            is_ld;
    logic            accept;
    logic [1:0]      cnt;
    logic            dst_ram;
    logic            dst_tmr;
    logic            ld;
    logic [XLEN-1:0] wdata_q;

    assign addr   = req_addr;
    assign is_ram = (addr.ram.region == RAM_REGION);
    assign is_tmr = (addr.mmio.region == MMIO_REGION);
    // A store wins if both strobes come together.
    assign is_ld  = req_le && !req_we;
    assign accept = (req_we || req_le) && !stage_busy;

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            ram_we  <= 1'b0;
            ram_re  <= 1'b0;
            tmr_we  <= 1'b0;
            tmr_re  <= 1'b0;
            cnt     <= '0;
            dst_ram <= 1'b0;
            dst_tmr <= 1'b0;
            ld      <= 1'b0;
        end else begin
            ram_we <= accept && is_ram && req_we;
            ram_re <= accept && is_ram && is_ld;
            tmr_we <= accept && is_tmr && req_we;
            tmr_re <= accept && is_tmr && is_ld;
            if (accept) begin
                cnt     <= (is_ram && is_ld) ? 2'(RAM_RD_LAT) : 2'd1;
                dst_ram <= is_ram;
                dst_tmr <= is_tmr;
                ld      <= is_ld;
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Payload.
    always_ff @(posedge CLK) begin
        if (accept) begin
            ram_idx <= addr.ram.word;
            tmr_sel <= addr.mmio.sel;
            wdata_q <= req_wdata;
        end
    end

    assign ram_wdata  = wdata_q;
    assign tmr_wdata  = wdata_q;
    assign stage_busy = (cnt != '0);

    always_comb begin
        if (!ld) begin
            stage_rdata = '0;
        end else if (dst_ram) begin
            stage_rdata = ram_rdata;
        end else if (dst_tmr) begin
            stage_rdata = tmr_rdata;
        end else begin
            stage_rdata = '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/shared_ram.sv ====
/* Shared word RAM.
   Synchronous write, registered address and output for a two-cycle read. */

`timescale 1ns/100ps
`default_nettype none

module shared_ram
    import bus_pkg::*;
    import mem_map_pkg::*;
(
    input  logic                 CLK,
    input  logic [RAM_IDX_W-1:0] ram_idx,
    input  logic                 ram_we,
    input  logic                 ram_re,
    input  logic [XLEN-1:0]      ram_wdata,
    output logic [XLEN-1:0]      ram_rdata
);

    logic [XLEN-1:0]      mem [0:RAM_WORDS-1];
    logic [RAM_IDX_W-1:0] rd_idx;

    always_ff @(posedge CLK) begin
        if (ram_we) begin
            mem[ram_idx] <= ram_wdata;
        end
    end

    // Read address held until the next read strobe.
    always_ff @(posedge CLK) begin
        if (ram_re) begin
            rd_idx <= ram_idx;
        end
    end

    always_ff @(posedge CLK) begin
        ram_rdata <= mem[rd_idx];
    end

endmodule

`default_nettype wire

// ==== dual_core_bus.f ====
design/bus_pkg.sv
design/mem_map_pkg.sv
design/bus_arbiter.sv
design/req_stage.sv
design/shared_ram.sv
design/mmio_regs.sv
design/dual_core_bus.sv
tests/tb_dual_core_bus.sv

// ==== tests/tb_dual_core_bus.sv ====
/* Testbench for the dual-core shared bus.
   Random two-core RAM traffic, then timer, software interrupt and unmapped accesses. */

`timescale 1ns/100ps
`default_nettype none

module tb_dual_core_bus
    import bus_pkg::*;
    import mem_map_pkg::*;
();

    localparam int N_OPS   = 60;
    localparam int N_WORDS = 64;
    localparam int DIR_OPS = 96;
    localparam int OP_CYC  = 24;
    localparam int MAX_CYC = 4 * (2 * N_OPS + DIR_OPS) * OP_CYC;
    localparam int WINDOW  = 40;
    localparam logic [CPUSTATE_W-1:0] S_EX = 4'd2;
    localparam logic [REGION_W-1:0] NO_REGION = 4'h5;

    logic                            CLK;
    logic                            RST_X;
    logic [1:0][CPUSTATE_W-1:0]      cpustate;
    logic [1:0][XLEN-1:0]            paddr;
    logic [1:0][XLEN-1:0]            wdata;
    logic [1:0]                      we;
    logic [1:0]                      le;
    wire  [1:0][XLEN-1:0]            rdata;
    wire  [1:0]                      busy;
    wire  [XLEN-1:0]                 mip;

    // Reference state.
    logic [XLEN-1:0] ram_model [N_WORDS];
    bit              written [N_WORDS];
    logic [63:0]     cmp_model;
    int              cycles;
    int              checks;
    int              errs;
    int              iso_errs;
    int              fair_errs;
    int              since_done [2];
    bit   [1:0]      pending;
    bit              other_pend;
    bit              fair_on;
    int              last_done;

    dual_core_bus u_dual_core_bus (
        .CLK       (CLK),
        .RST_X     (RST_X),
        .cpustate0 (cpustate[0]),
        .paddr0    (paddr[0]),
        .we0       (we[0]),
        .le0       (le[0]),
        .wdata0    (wdata[0]),
        .rdata0    (rdata[0]),
        .busy0     (busy[0]),
        .cpustate1 (cpustate[1]),
        .paddr1    (paddr[1]),
        .we1       (we[1]),
        .le1       (le[1]),
        .wdata1    (wdata[1]),
        .rdata1    (rdata[1]),
        .busy1     (busy[1]),
        .mip       (mip)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYC) begin
            $display("Run stopped after %0d cycles, a transaction never completed.", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    // ************************************************************
    // Port monitors
    // ************************************************************
    always @(negedge CLK) begin
        if (RST_X) begin
            for (int n = 0; n < 2; n++) begin
                if (!busy[n]) begin
                    assert (busy[1-n] && rdata[1-n] == '0) else begin
                        $display("[ERROR] %0t: idle core %0d shows busy=%b rdata=%h",
                                 $time, 1 - n, busy[1-n], rdata[1-n]);
                        iso_errs++;
                    end
                end
                if (fair_on) begin
                    since_done[n]++;
                    assert (since_done[n] <= WINDOW) else begin
                        $display("[ERROR] %0t: core %0d idle for %0d cycles", $time, n,
                                 since_done[n]);
                        fair_errs++;
                        since_done[n] = 0;
                    end
                end
            end
        end
    end

    function automatic logic [XLEN-1:0] ram_addr(input int idx);
        bus_addr_u a;
        a          = '0;
        a.ram.region = RAM_REGION;
        a.ram.word   = RAM_IDX_W'(idx);
        return a;
    endfunction

    function automatic logic [XLEN-1:0] tmr_addr(input logic [TMR_SEL_W-1:0] sel);
        bus_addr_u a;
        a           = '0;
        a.mmio.region = MMIO_REGION;
        a.mmio.sel    = sel;
        return a;
    endfunction

    task automatic expect_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                               input string what);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t: %s returned %h, expected %h", $time, what, got, exp);
            errs++;
        end
    endtask

    // One core operation. Decode hold, wait for grant, strobe, wait for completion.
    task automatic issue_op(input int n, input bit st, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] d, output logic [XLEN-1:0] rd);
        int hold;
        hold = 1 + $urandom % 4;
        repeat (hold) begin
            @(posedge CLK);
            #1;
        end
        cpustate[n] = S_EX;
        pending[n]  = 1'b1;
        while (busy[n]) begin
            @(posedge CLK);
            #1;
        end
        pending[n] = 1'b0;
        paddr[n]   = a;
        wdata[n]   = d;
        we[n]      = st;
        le[n]      = !st;
        @(posedge CLK);
        #1;
        we[n] = 1'b0;
        le[n] = 1'b0;
        assert (busy[n]) else begin
            $display("[ERROR] %0t: core %0d busy did not rise after its strobe", $time, n);
            errs++;
        end
        while (busy[n]) begin
            @(posedge CLK);
            #1;
        end
        rd = rdata[n];
        if (fair_on) begin
            assert (!(last_done == n && other_pend)) else begin
                $display("[ERROR] %0t: core %0d completed twice while core %0d waited",
                         $time, n, 1 - n);
                fair_errs++;
            end
        end
        other_pend    = pending[1-n];
        last_done     = n;
        since_done[n] = 0;
        cpustate[n]   = S_ID;
    endtask

    task automatic run_traffic(input int n);
        int              idx;
        bit              st;
        logic [XLEN-1:0] d;
        logic [XLEN-1:0] rd;
        for (int i = 0; i < N_OPS; i++) begin
            idx = $urandom % N_WORDS;
            st  = !written[idx] || ($urandom % 2 == 0);
            d   = $urandom;
            issue_op(n, st, ram_addr(idx), d, rd);
            if (st) begin
                ram_model[idx] = d;
                written[idx]   = 1'b1;
            end else begin
                expect_word(rd, ram_model[idx], "RAM load");
            end
        end
        fair_on = 1'b0;
    endtask

    // ************************************************************
    // Test sequence
    // ************************************************************
    initial begin
        int              seed;
        int              base;
        int              total;
        logic [XLEN-1:0] t0;
        logic [XLEN-1:0] t1;
        logic [XLEN-1:0] rd;
        logic [XLEN-1:0] wd;
        seed      = $urandom(91);
        RST_X     = 1'b0;
        cpustate  = {S_ID, S_ID};
        paddr     = '0;
        wdata     = '0;
        we        = '0;
        le        = '0;
        cycles    = 0;
        checks    = 0;
        errs      = 0;
        iso_errs  = 0;
        fair_errs = 0;
        pending   = '0;
        fair_on   = 1'b0;
        last_done = -1;
        cmp_model = '1;
        repeat (4) @(posedge CLK);
        #1;
        RST_X = 1'b1;

        base    = errs;
        fair_on = 1'b1;
        fork
            run_traffic(0);
            run_traffic(1);
        join
        $display("Test 1 RAM coherence: %0d errors", errs - base);
        $display("Test 3 fair switching: %0d errors", fair_errs);

        base = errs;
        issue_op(0, 1'b0, tmr_addr(TMR_MTIME_LO), '0, t0);
        issue_op(0, 1'b0, tmr_addr(TMR_MTIME_LO), '0, t1);
        checks++;
        assert (t1 > t0) else begin
            $display("[ERROR] %0t: mtime read %0d after %0d", $time, t1, t0);
            errs++;
        end
        issue_op(0, 1'b1, tmr_addr(TMR_MTIMECMP_HI), '0, rd);
        expect_word(mip, 32'h0000_0000, "mip with compare high");
        cmp_model = {32'h0, t1 + 32'd8};
        issue_op(0, 1'b1, tmr_addr(TMR_MTIMECMP_LO), cmp_model[31:0], rd);
        for (int c = 0; c < 20 && !mip[7]; c++) begin
            @(posedge CLK);
            #1;
        end
        expect_word(mip, 32'h0000_0080, "mip after compare write");
        issue_op(0, 1'b0, tmr_addr(TMR_MTIMECMP_LO), '0, rd);
        expect_word(rd, cmp_model[31:0], "mtimecmp low");
        cmp_model = '1;
        issue_op(0, 1'b1, tmr_addr(TMR_MTIMECMP_LO), '1, rd);
        issue_op(0, 1'b1, tmr_addr(TMR_MTIMECMP_HI), '1, rd);
        expect_word(mip, 32'h0000_0000, "mip after compare clear");
        $display("Test 4 timer: %0d errors", errs - base);

        base = errs;
        issue_op(0, 1'b1, tmr_addr(TMR_MSIP), 32'd1, rd);
        expect_word(mip, 32'h0000_0008, "mip with MSIP set");
        issue_op(0, 1'b0, tmr_addr(TMR_MSIP), '0, rd);
        expect_word(rd, 32'd1, "msip read");
        issue_op(0, 1'b1, tmr_addr(TMR_MSIP), '0, rd);
        expect_word(mip, 32'h0000_0000, "mip with MSIP clear");
        issue_op(0, 1'b0, tmr_addr(TMR_MSIP), '0, rd);
        expect_word(rd, '0, "msip read");
        $display("Test 5 software interrupt: %0d errors", errs - base);

        // Offset 0x8 aliases RAM word 2 and the mtimecmp low select.
        base = errs;
        wd   = $urandom;
        issue_op(0, 1'b1, ram_addr(2), wd, rd);
        ram_model[2] = wd;
        written[2]   = 1'b1;
        issue_op(0, 1'b0, {NO_REGION, 28'h000_0008}, '0, rd);
        expect_word(rd, '0, "unmapped load");
        issue_op(0, 1'b1, {NO_REGION, 28'h000_0008}, ~wd, rd);
        for (int i = 0; i < N_WORDS; i++) begin
            if (written[i]) begin
                issue_op(0, 1'b0, ram_addr(i), '0, rd);
                expect_word(rd, ram_model[i], "RAM after unmapped store");
            end
        end
        issue_op(0, 1'b0, tmr_addr(TMR_MTIMECMP_LO), '0, rd);
        expect_word(rd, cmp_model[31:0], "mtimecmp after unmapped store");
        issue_op(0, 1'b0, tmr_addr(TMR_MSIP), '0, rd);
        expect_word(rd, '0, "msip after unmapped store");
        $display("Test 6 unmapped region: %0d errors", errs - base);

        $display("Test 2 isolation: %0d errors", iso_errs);
        total = errs + iso_errs + fair_errs;
        $display("Checks: %0d, errors: %0d, cycles: %0d", checks, total, cycles);
        if (total == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
